/* hw/accum_params.svh */
`ifndef ACCUM_PARAMS_SVH
`define ACCUM_PARAMS_SVH

// datapath width, kept a multiple of the nibble width.
`define ACCUM_WIDTH 16

`define NIBBLE_WIDTH 4 // one ripple block.

`define DIGIT_COUNT (`ACCUM_WIDTH / 4) // hex digits on the board.

`endif

/* hw/accumCtrlPkg.sv */
package accumCtrlPkg;

	// opcode from the 2-bit selector.
	typedef enum logic [1:0] {
		OP_ADD   = 2'b00,
		OP_SUB   = 2'b01,
		OP_LOAD  = 2'b10,
		OP_CLEAR = 2'b11
	} opCodeT;

	// run-button controller states.
	typedef enum logic [1:0] {
		ST_IDLE    = 2'd0,
		ST_EXECUTE = 2'd1,
		ST_HOLD    = 2'd2
	} ctrlStateT;

endpackage

/* hw/accumDataPkg.sv */
`include "accum_params.svh"

package accumDataPkg;

	typedef logic [`ACCUM_WIDTH-1:0] wordT; // accumulator and operand word.

	typedef logic [`NIBBLE_WIDTH-1:0] nibbleT; // one adder block or hex digit.

	// active low, bit 6 is segment g and bit 0 is segment a.
	typedef logic [6:0] segT;

endpackage

/* hw/rippleNibbleAdder.sv */
`include "accum_params.svh"

module rippleNibbleAdder (
	input  accumDataPkg::nibbleT x,
	input  accumDataPkg::nibbleT y,
	input  logic                 cin,
	output accumDataPkg::nibbleT s,
	output logic                 cout
);

	logic [`NIBBLE_WIDTH:0] c; // ripple chain.

	assign c[0] = cin;

	// one full adder per bit.
	for (genvar i = 0; i < `NIBBLE_WIDTH; i++) begin : gBit
		assign s[i] = x[i] ^ y[i] ^ c[i];
		assign c[i+1] = (x[i] & y[i]) | (y[i] & c[i]) | (c[i] & x[i]); // majority.
	end

	assign cout = c[`NIBBLE_WIDTH];

endmodule

/* hw/carrySelectAdder.sv */
`include "accum_params.svh"

module carrySelectAdder (
	input  accumDataPkg::wordT a,
	input  accumDataPkg::wordT b,
	input  logic               cin,
	output accumDataPkg::wordT sum,
	output logic               cout
);

	localparam int NUM_BLOCKS = `ACCUM_WIDTH / `NIBBLE_WIDTH;

	logic [NUM_BLOCKS:0] blockCarry; // carry into each block.

	assign blockCarry[0] = cin;

	for (genvar g = 0; g < NUM_BLOCKS; g++) begin : gBlock
		if (g == 0) begin : gLow
			// lowest block sees the real carry-in.
			rippleNibbleAdder uAdd (
				.x    (a[0 +: `NIBBLE_WIDTH]),
				.y    (b[0 +: `NIBBLE_WIDTH]),
				.cin  (blockCarry[0]),
				.s    (sum[0 +: `NIBBLE_WIDTH]),
				.cout (blockCarry[1])
			);
		end else begin : gUpper
			accumDataPkg::nibbleT sum0, sum1;
			logic                 carry0, carry1;

			rippleNibbleAdder uAdd0 (
				.x    (a[g*`NIBBLE_WIDTH +: `NIBBLE_WIDTH]),
				.y    (b[g*`NIBBLE_WIDTH +: `NIBBLE_WIDTH]),
				.cin  (1'b0),
				.s    (sum0),
				.cout (carry0)
			);

			rippleNibbleAdder uAdd1 (
				.x    (a[g*`NIBBLE_WIDTH +: `NIBBLE_WIDTH]),
				.y    (b[g*`NIBBLE_WIDTH +: `NIBBLE_WIDTH]),
				.cin  (1'b1),
				.s    (sum1),
				.cout (carry1)
			);

			assign sum[g*`NIBBLE_WIDTH +: `NIBBLE_WIDTH] = blockCarry[g] ? sum1 : sum0;
			assign blockCarry[g+1] = carry0 | (blockCarry[g] & carry1); // select the carry.
		end
	end

	assign cout = blockCarry[NUM_BLOCKS];

endmodule

/* hw/operandSelect.sv */
module operandSelect (
	input  logic               clk,
	input  logic               rstN,
	input  accumDataPkg::wordT switches,
	input  logic               captureOperand,
	input  logic               subtract,
	output accumDataPkg::wordT operandValue,
	output accumDataPkg::wordT adderB,
	output logic               adderCin
);

	accumDataPkg::wordT operandReg;

	always_ff @(posedge clk) begin
		if (!rstN) begin
			operandReg <= '0;
		end else if (captureOperand) begin
			operandReg <= switches; // sampled at the start edge.
		end
	end

	assign operandValue = operandReg;

	// two's complement negate for subtract.
	assign adderB = subtract ? ~operandReg : operandReg;
	assign adderCin = subtract;

endmodule

/* hw/accumRegister.sv */
`include "accum_params.svh"

module accumRegister (
	input  logic               clk,
	input  logic               rstN,
	input  logic               accWrite,
	input  logic               clearAcc,
	input  logic               loadDirect,
	input  logic               subtract,
	input  accumDataPkg::wordT sum,
	input  logic               carryOut,
	input  accumDataPkg::wordT operandValue,
	output accumDataPkg::wordT accum,
	output logic               carry,
	output logic               zero,
	output logic               overflow
);

	localparam int MSB = `ACCUM_WIDTH - 1;

	accumDataPkg::wordT nextValue;
	logic               nextCarry;
	logic               nextOverflow;
	logic               bSign;

	assign bSign = subtract ? ~operandValue[MSB] : operandValue[MSB]; // sign the adder sees.

	always_comb begin
		nextValue = sum;
		nextCarry = carryOut;
		nextOverflow = (accum[MSB] == bSign) && (sum[MSB] != accum[MSB]);
		if (clearAcc) begin
			nextValue = '0;
			nextCarry = 1'b0;
			nextOverflow = 1'b0;
		end else if (loadDirect) begin
			nextValue = operandValue;
			nextCarry = 1'b0;
			nextOverflow = 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (!rstN) begin
			accum <= '0;
			carry <= 1'b0;
			zero <= 1'b1; // zero accumulator after reset.
			overflow <= 1'b0;
		end else if (accWrite) begin
			accum <= nextValue;
			carry <= nextCarry;
			zero <= (nextValue == '0);
			overflow <= nextOverflow;
		end
	end

endmodule

/* hw/accumControl.sv */
module accumControl (
	input  logic                 clk,
	input  logic                 rstN,
	input  logic                 run,
	input  accumCtrlPkg::opCodeT opSel,
	output logic                 captureOperand,
	output logic                 subtract,
	output logic                 loadDirect,
	output logic                 clearAcc,
	output logic                 accWrite,
	output logic                 done
);

	accumCtrlPkg::ctrlStateT state, nextState;
	accumCtrlPkg::opCodeT    opReg;
	logic                    start;
	logic                    executing;

	assign start = (state == accumCtrlPkg::ST_IDLE) && run;
	assign executing = (state == accumCtrlPkg::ST_EXECUTE);

	always_comb begin
		nextState = state;
		case (state)
			accumCtrlPkg::ST_IDLE: begin
				if (run) begin
					nextState = accumCtrlPkg::ST_EXECUTE;
				end
			end
			accumCtrlPkg::ST_EXECUTE: begin
				nextState = accumCtrlPkg::ST_HOLD; // one cycle only.
			end
			accumCtrlPkg::ST_HOLD: begin
				if (!run) begin
					nextState = accumCtrlPkg::ST_IDLE; // wait for release.
				end
			end
			default: begin
				nextState = accumCtrlPkg::ST_IDLE;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rstN) begin
			state <= accumCtrlPkg::ST_IDLE;
			opReg <= accumCtrlPkg::OP_ADD;
		end else begin
			state <= nextState;
			if (start) begin
				opReg <= opSel; // opcode held through execute.
			end
		end
	end

	assign captureOperand = start;
	assign accWrite = executing;
	assign done = executing;

	// strobes decoded from the latched opcode.
	assign subtract = executing && (opReg == accumCtrlPkg::OP_SUB);
	assign loadDirect = executing && (opReg == accumCtrlPkg::OP_LOAD);
	assign clearAcc = executing && (opReg == accumCtrlPkg::OP_CLEAR);

endmodule

/* hw/hexDisplay.sv */
`include "accum_params.svh"

module hexDisplay (
	input  accumDataPkg::wordT value,
	output accumDataPkg::segT  hex0,
	output accumDataPkg::segT  hex1,
	output accumDataPkg::segT  hex2,
	output accumDataPkg::segT  hex3
);

	accumDataPkg::segT digits [`DIGIT_COUNT];

	function automatic accumDataPkg::segT segOf(input accumDataPkg::nibbleT n);
		case (n)
			4'h0: segOf = 7'b1000000;
			4'h1: segOf = 7'b1111001;
			4'h2: segOf = 7'b0100100;
			4'h3: segOf = 7'b0110000;
			4'h4: segOf = 7'b0011001;
			4'h5: segOf = 7'b0010010;
			4'h6: segOf = 7'b0000010;
			4'h7: segOf = 7'b1111000;
			4'h8: segOf = 7'b0000000;
			4'h9: segOf = 7'b0010000;
			4'hA: segOf = 7'b0001000;
			4'hB: segOf = 7'b0000011; // lower case b.
			4'hC: segOf = 7'b1000110;
			4'hD: segOf = 7'b0100001; // lower case d.
			4'hE: segOf = 7'b0000110;
			default: segOf = 7'b0001110;
		endcase
	endfunction

	always_comb begin
		for (int i = 0; i < `DIGIT_COUNT; i++) begin
			digits[i] = segOf(value[i*4 +: 4]); // digit 0 is the low nibble.
		end
	end

	assign hex0 = digits[0];
	assign hex1 = digits[1];
	assign hex2 = digits[2];
	assign hex3 = digits[3];

endmodule

/* hw/accumTop.sv */
`include "accum_params.svh"

module accumTop (
	input  logic                 clk,
	input  logic                 rstN,
	input  accumDataPkg::wordT   switches,
	input  accumCtrlPkg::opCodeT opSel,
	input  logic                 run,
	output accumDataPkg::wordT   accum,
	output logic                 carry,
	output logic                 zero,
	output logic                 overflow,
	output logic                 done,
	output accumDataPkg::segT    hex0,
	output accumDataPkg::segT    hex1,
	output accumDataPkg::segT    hex2,
	output accumDataPkg::segT    hex3
);

	logic               captureOperand, subtract, loadDirect, clearAcc, accWrite;
	logic               adderCin, carryOut;
	accumDataPkg::wordT operandValue, adderB, sum;
	accumDataPkg::segT  digits [`DIGIT_COUNT];

	accumControl uControl (
		.clk            (clk),
		.rstN           (rstN),
		.run            (run),
		.opSel          (opSel),
		.captureOperand (captureOperand),
		.subtract       (subtract),
		.loadDirect     (loadDirect),
		.clearAcc       (clearAcc),
		.accWrite       (accWrite),
		.done           (done)
	);

	operandSelect uOperand (
		.clk            (clk),
		.rstN           (rstN),
		.switches       (switches),
		.captureOperand (captureOperand),
		.subtract       (subtract),
		.operandValue   (operandValue),
		.adderB         (adderB),
		.adderCin       (adderCin)
	);

	carrySelectAdder uAdder (
		.a    (accum),
		.b    (adderB),
		.cin  (adderCin),
		.sum  (sum),
		.cout (carryOut)
	);

	accumRegister uAccum (
		.clk          (clk),
		.rstN         (rstN),
		.accWrite     (accWrite),
		.clearAcc     (clearAcc),
		.loadDirect   (loadDirect),
		.subtract     (subtract),
		.sum          (sum),
		.carryOut     (carryOut),
		.operandValue (operandValue),
		.accum        (accum),
		.carry        (carry),
		.zero         (zero),
		.overflow     (overflow)
	);

	hexDisplay uDisplay (
		.value (accum),
		.hex0  (digits[0]),
		.hex1  (digits[1]),
		.hex2  (digits[2]),
		.hex3  (digits[3])
	);

	assign hex0 = digits[0];
	assign hex1 = digits[1];
	assign hex2 = digits[2];
	assign hex3 = digits[3];

endmodule

/* testbench/accumTb.sv */
`include "accum_params.svh"

module accumTb;

	localparam int TIMEOUT_CYCLES = 50;
	localparam int RANDOM_OPS = 200;
	localparam int HOLD_CYCLES = 10;
	localparam int MSB = `ACCUM_WIDTH - 1;

	typedef struct packed {
		accumCtrlPkg::opCodeT op;
		accumDataPkg::wordT   operand;
		accumDataPkg::wordT   expAcc;
		logic                 expCarry;
		logic                 expZero;
		logic                 expOverflow;
	} stepT;

	logic                 clk;
	logic                 rstN;
	accumDataPkg::wordT   switches;
	accumCtrlPkg::opCodeT opSel;
	logic                 run;
	accumDataPkg::wordT   accum;
	logic                 carry, zero, overflow, done;
	accumDataPkg::segT    hex0, hex1, hex2, hex3;

	stepT               steps [$];
	int                 errorCount;
	int                 timeoutCount;
	logic [31:0]        lcgState;
	accumDataPkg::wordT refAcc;
	logic               refCarry, refZero, refOverflow;

	accumTop u_dut (
		.clk      (clk),
		.rstN     (rstN),
		.switches (switches),
		.opSel    (opSel),
		.run      (run),
		.accum    (accum),
		.carry    (carry),
		.zero     (zero),
		.overflow (overflow),
		.done     (done),
		.hex0     (hex0),
		.hex1     (hex1),
		.hex2     (hex2),
		.hex3     (hex3)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	function automatic logic [31:0] nextRandom();
		lcgState = lcgState * 32'd1103515245 + 32'd12345;
		return lcgState;
	endfunction

	// active low, g down to a.
	function automatic accumDataPkg::segT segmentFor(input logic [3:0] nib);
		case (nib)
			4'h0: return 7'b1000000;
			4'h1: return 7'b1111001;
			4'h2: return 7'b0100100;
			4'h3: return 7'b0110000;
			4'h4: return 7'b0011001;
			4'h5: return 7'b0010010;
			4'h6: return 7'b0000010;
			4'h7: return 7'b1111000;
			4'h8: return 7'b0000000;
			4'h9: return 7'b0010000;
			4'hA: return 7'b0001000;
			4'hB: return 7'b0000011;
			4'hC: return 7'b1000110;
			4'hD: return 7'b0100001;
			4'hE: return 7'b0000110;
			default: return 7'b0001110;
		endcase
	endfunction

	task automatic addStep(input accumCtrlPkg::opCodeT op, input accumDataPkg::wordT operand,
			input accumDataPkg::wordT expAcc, input logic c, input logic z, input logic v);
		stepT s;
		s.op = op;
		s.operand = operand;
		s.expAcc = expAcc;
		s.expCarry = c;
		s.expZero = z;
		s.expOverflow = v;
		steps.push_back(s);
	endtask

	task automatic buildTable();
		addStep(accumCtrlPkg::OP_LOAD, 16'h1234, 16'h1234, 1'b0, 1'b0, 1'b0);
		addStep(accumCtrlPkg::OP_ADD, 16'h0001, 16'h1235, 1'b0, 1'b0, 1'b0);
		addStep(accumCtrlPkg::OP_LOAD, 16'hFFFF, 16'hFFFF, 1'b0, 1'b0, 1'b0);
		addStep(accumCtrlPkg::OP_ADD, 16'h0001, 16'h0000, 1'b1, 1'b1, 1'b0); // carry through all.
		addStep(accumCtrlPkg::OP_LOAD, 16'h7FFF, 16'h7FFF, 1'b0, 1'b0, 1'b0);
		addStep(accumCtrlPkg::OP_ADD, 16'h0001, 16'h8000, 1'b0, 1'b0, 1'b1);
		addStep(accumCtrlPkg::OP_SUB, 16'h0001, 16'h7FFF, 1'b1, 1'b0, 1'b1);
		addStep(accumCtrlPkg::OP_SUB, 16'h8000, 16'hFFFF, 1'b0, 1'b0, 1'b1); // borrow.
		addStep(accumCtrlPkg::OP_CLEAR, 16'h1234, 16'h0000, 1'b0, 1'b1, 1'b0);
		addStep(accumCtrlPkg::OP_SUB, 16'h0001, 16'hFFFF, 1'b0, 1'b0, 1'b0);
		addStep(accumCtrlPkg::OP_ADD, 16'h0001, 16'h0000, 1'b1, 1'b1, 1'b0);
		addStep(accumCtrlPkg::OP_ADD, 16'hA5C3, 16'hA5C3, 1'b0, 1'b0, 1'b0);
		addStep(accumCtrlPkg::OP_SUB, 16'hA5C3, 16'h0000, 1'b1, 1'b1, 1'b0);
		addStep(accumCtrlPkg::OP_LOAD, 16'h8000, 16'h8000, 1'b0, 1'b0, 1'b0);
		addStep(accumCtrlPkg::OP_ADD, 16'h8000, 16'h0000, 1'b1, 1'b1, 1'b1);
		addStep(accumCtrlPkg::OP_SUB, 16'h0000, 16'h0000, 1'b1, 1'b1, 1'b0);
		addStep(accumCtrlPkg::OP_ADD, 16'h0F0F, 16'h0F0F, 1'b0, 1'b0, 1'b0);
		addStep(accumCtrlPkg::OP_ADD, 16'hF0F1, 16'h0000, 1'b1, 1'b1, 1'b0);
	endtask

	task automatic modelStep(input accumCtrlPkg::opCodeT op, input accumDataPkg::wordT operand);
		logic [`ACCUM_WIDTH:0] wide;
		accumDataPkg::wordT    result;
		case (op)
			accumCtrlPkg::OP_ADD: begin
				wide = {1'b0, refAcc} + {1'b0, operand};
				result = wide[MSB:0];
				refCarry = wide[`ACCUM_WIDTH];
				refOverflow = (refAcc[MSB] == operand[MSB]) && (result[MSB] != refAcc[MSB]);
			end
			accumCtrlPkg::OP_SUB: begin
				result = refAcc - operand;
				refCarry = (refAcc >= operand); // set when nothing is borrowed.
				refOverflow = (refAcc[MSB] != operand[MSB]) && (result[MSB] != refAcc[MSB]);
			end
			accumCtrlPkg::OP_LOAD: begin
				result = operand;
				refCarry = 1'b0;
				refOverflow = 1'b0;
			end
			default: begin
				result = '0;
				refCarry = 1'b0;
				refOverflow = 1'b0;
			end
		endcase
		refAcc = result;
		refZero = (result == '0);
	endtask

	task automatic checkOutputs(input accumDataPkg::wordT expAcc, input logic c, input logic z,
			input logic v, input string what);
		if (accum !== expAcc) begin
			$display("FAIL %0t: %s accum %h, expected %h", $time, what, accum, expAcc);
			errorCount++;
		end
		if (carry !== c) begin
			$display("FAIL %0t: %s carry %b, expected %b", $time, what, carry, c);
			errorCount++;
		end
		if (zero !== z) begin
			$display("FAIL %0t: %s zero %b, expected %b", $time, what, zero, z);
			errorCount++;
		end
		if (overflow !== v) begin
			$display("FAIL %0t: %s overflow %b, expected %b", $time, what, overflow, v);
			errorCount++;
		end
	endtask

	task automatic checkDisplay(input accumDataPkg::wordT expAcc, input string what);
		accumDataPkg::segT shown [`DIGIT_COUNT];
		accumDataPkg::segT want;
		shown[0] = hex0;
		shown[1] = hex1;
		shown[2] = hex2;
		shown[3] = hex3;
		for (int i = 0; i < `DIGIT_COUNT; i++) begin
			want = segmentFor(expAcc[i*4 +: 4]);
			if (shown[i] !== want) begin
				$display("FAIL %0t: %s hex%0d %b, expected %b", $time, what, i, shown[i], want);
				errorCount++;
			end
		end
	endtask

	// one run press, held for holdCycles extra cycles after done.
	task automatic runOperation(input accumCtrlPkg::opCodeT op, input accumDataPkg::wordT operand,
			input int holdCycles, output bit timedOut);
		int                 cycles;
		accumDataPkg::wordT heldAcc;
		timedOut = 1'b0;
		cycles = 0;
		@(posedge clk);
		switches <= operand;
		opSel <= op;
		run <= 1'b1;
		do begin
			@(negedge clk);
			cycles++;
		end while (!done && cycles < TIMEOUT_CYCLES);
		if (!done) begin
			$display("timeout: done never rose within %0d cycles of run", TIMEOUT_CYCLES);
			timeoutCount++;
			timedOut = 1'b1;
		end else begin
			if (cycles != 2) begin
				$display("FAIL %0t: done after %0d cycles, expected 2", $time, cycles);
				errorCount++;
			end
			@(negedge clk);
			if (done !== 1'b0) begin
				$display("FAIL %0t: done high for more than one cycle", $time);
				errorCount++;
			end
			heldAcc = accum;
			for (int i = 0; i < holdCycles; i++) begin
				@(negedge clk);
				if (done !== 1'b0 || accum !== heldAcc) begin
					$display("FAIL %0t: operation repeated while run held high", $time);
					errorCount++;
				end
			end
			@(posedge clk);
			run <= 1'b0;
			repeat (2) @(posedge clk);
		end
	endtask

	initial begin
		bit                   timedOut;
		logic [31:0]          rnd;
		accumCtrlPkg::opCodeT op;
		accumDataPkg::wordT   operand;
		errorCount = 0;
		timeoutCount = 0;
		timedOut = 1'b0;
		lcgState = 32'd45452;
		rstN = 1'b0;
		run = 1'b0;
		switches = '0;
		opSel = accumCtrlPkg::OP_ADD;
		buildTable();
		repeat (16) @(posedge clk);
		rstN <= 1'b1;
		@(negedge clk);

		refAcc = '0;
		refCarry = 1'b0;
		refZero = 1'b1;
		refOverflow = 1'b0;
		if (done !== 1'b0) begin
			$display("FAIL %0t: done %b after reset, expected 0", $time, done);
			errorCount++;
		end
		checkOutputs('0, 1'b0, 1'b1, 1'b0, "after reset");
		checkDisplay('0, "after reset");

		for (int i = 0; i < steps.size() && !timedOut; i++) begin
			runOperation(steps[i].op, steps[i].operand, HOLD_CYCLES, timedOut);
			if (!timedOut) begin
				checkOutputs(steps[i].expAcc, steps[i].expCarry, steps[i].expZero,
					steps[i].expOverflow, $sformatf("step %0d", i));
				checkDisplay(steps[i].expAcc, $sformatf("step %0d", i));
				modelStep(steps[i].op, steps[i].operand); // keep the model in step.
			end
		end

		for (int n = 0; n < RANDOM_OPS && !timedOut; n++) begin
			rnd = nextRandom();
			op = accumCtrlPkg::opCodeT'(rnd[31:30]);
			rnd = nextRandom();
			operand = rnd[31:16];
			modelStep(op, operand);
			runOperation(op, operand, 0, timedOut);
			if (!timedOut) begin
				checkOutputs(refAcc, refCarry, refZero, refOverflow,
					$sformatf("random op %0d (%s %h)", n, op.name(), operand));
				checkDisplay(refAcc, $sformatf("random op %0d", n));
			end
		end

		$display("errors: %0d value mismatches, %0d timeouts", errorCount, timeoutCount);
		if (errorCount == 0 && timeoutCount == 0) begin
			$display("*** TEST PASSED ***");
		end else begin
			$display("*** TEST FAILED ***");
		end
		$finish;
	end

endmodule

/* compile.f */
+incdir+hw
hw/accumCtrlPkg.sv
hw/accumDataPkg.sv
hw/rippleNibbleAdder.sv
hw/carrySelectAdder.sv
hw/operandSelect.sv
hw/accumRegister.sv
hw/accumControl.sv
hw/hexDisplay.sv
hw/accumTop.sv
testbench/accumTb.sv
